/* sources.f */
+incdir+tb
source/fpu_pkg.sv
source/fpu_issue_stage.sv
source/fpu_sign_move_unit.sv
source/fpu_compare_unit.sv
source/fpu_result_merge.sv
source/fpu_pipe_top.sv
tb/tb_fpu_pipe.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_fpu_pipe
FILELIST  = sources.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
PASS_MSG  = all tests passed

SRCS = $(wildcard source/*.sv) $(wildcard tb/*.sv) $(wildcard tb/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM) 2>&1)"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* tb/fpu_ref_model.svh */
`ifndef FPU_REF_MODEL_SVH
`define FPU_REF_MODEL_SVH

// Single value seen through a 64-bit register, canonical NaN unless boxed
function automatic single_t unboxed_single(input flen_t value);
  if (value[63:32] == 32'hffff_ffff) begin
    return value[31:0];
  end
  return 32'h7fc0_0000;
endfunction

function automatic flen_t boxed(input single_t value);
  return {32'hffff_ffff, value};
endfunction

function automatic logic is_nan_s(input single_t value);
  return (value[30:23] == 8'hff) && (|value[22:0]);
endfunction

function automatic logic is_snan_s(input single_t value);
  return is_nan_s(value) && !value[22];
endfunction

// Maps a single to an unsigned key whose order is the numeric order, -0 below +0
function automatic logic [31:0] order_key(input single_t value);
  return value[31] ? ~value : (value | 32'h8000_0000);
endfunction

function automatic logic is_slow_op(input fpu_op_t op);
  return op inside {OP_FMIN_S, OP_FMAX_S, OP_FEQ_S, OP_FLT_S, OP_FLE_S};
endfunction

function automatic void model_result(input fpu_op_t op, input flen_t rs1, input flen_t rs2,
                                     output flen_t data, output fflags_t flags);
  single_t a;
  single_t b;
  logic    any_nan;
  logic    eq;
  logic    lt;
  a       = unboxed_single(rs1);
  b       = unboxed_single(rs2);
  any_nan = is_nan_s(a) || is_nan_s(b);
  eq      = (a == b) || ((~|a[30:0]) && (~|b[30:0]));
  lt      = (order_key(a) < order_key(b)) && !eq;
  data    = '0;
  flags   = '0;
  case (op)
    OP_FMV_X_W:  data = {{32{rs1[31]}}, rs1[31:0]};
    OP_FMV_W_X:  data = boxed(rs1[31:0]);
    OP_FSGNJ_S:  data = boxed({b[31], a[30:0]});
    OP_FSGNJN_S: data = boxed({~b[31], a[30:0]});
    OP_FSGNJX_S: data = boxed({a[31] ^ b[31], a[30:0]});
    OP_FSGNJ_D:  data = {rs2[63], rs1[62:0]};
    OP_FSGNJN_D: data = {~rs2[63], rs1[62:0]};
    OP_FSGNJX_D: data = {rs1[63] ^ rs2[63], rs1[62:0]};
    OP_FMIN_S, OP_FMAX_S: begin
      if (is_nan_s(a) && is_nan_s(b)) begin
        data = boxed(32'h7fc0_0000);
      end else if (is_nan_s(a)) begin
        data = boxed(b);
      end else if (is_nan_s(b)) begin
        data = boxed(a);
      end else if ((order_key(a) < order_key(b)) == (op == OP_FMIN_S)) begin
        data = boxed(a);
      end else begin
        data = boxed(b);
      end
      flags[NV_BIT] = is_snan_s(a) || is_snan_s(b);
    end
    OP_FEQ_S: begin
      data[0]       = !any_nan && eq;
      flags[NV_BIT] = is_snan_s(a) || is_snan_s(b);
    end
    OP_FLT_S: begin
      data[0]       = !any_nan && lt;
      flags[NV_BIT] = any_nan;
    end
    OP_FLE_S: begin
      data[0]       = !any_nan && (lt || eq);
      flags[NV_BIT] = any_nan;
    end
    default: data = '0;
  endcase
endfunction

`endif

/* tb/tb_fpu_pipe.sv */
`timescale 1ns/100ps

module tb_fpu_pipe;

  import fpu_pkg::*;

  `include "fpu_ref_model.svh"

  localparam int CLK_PERIOD      = 20;
  localparam int RESET_CYCLES    = 16;
  localparam int DRIVE_DELAY     = 2;
  localparam int NUM_TESTS       = 6;
  localparam int CYCLES_PER_TEST = 200;
  localparam int WATCHDOG_NS     = (RESET_CYCLES + NUM_TESTS * CYCLES_PER_TEST) * CLK_PERIOD;

  typedef struct packed {
    tag_t    tag;
    flen_t   data;
    fflags_t fflags;
    int      accept_cycle;
    int      latency;
  } expect_t;

  logic        i_clk;
  logic        i_reset_n;
  logic        i_flush;
  logic        i_valid;
  fpu_op_t     i_op;
  tag_t        i_tag;
  flen_t       i_rs1;
  flen_t       i_rs2;
  logic        o_ready;
  logic        o_valid;
  logic        i_ready;
  tag_t        o_tag;
  flen_t       o_data;
  fflags_t     o_fflags;

  expect_t     expect_q[$];
  int          cycle_no = 0;
  logic        check_latency;
  logic [31:0] rng_state;
  tag_t        next_tag;

  fpu_pipe_top dut_i (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_flush   (i_flush),
    .i_valid   (i_valid),
    .i_op      (i_op),
    .i_tag     (i_tag),
    .i_rs1     (i_rs1),
    .i_rs2     (i_rs2),
    .o_ready   (o_ready),
    .o_valid   (o_valid),
    .i_ready   (i_ready),
    .o_tag     (o_tag),
    .o_data    (o_data),
    .o_fflags  (o_fflags)
  );

  initial begin
    i_clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end
  end

  always @(posedge i_clk) begin
    cycle_no <= cycle_no + 1;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d cycles",
             RESET_CYCLES + NUM_TESTS * CYCLES_PER_TEST);
    stop_on_failure();
  end

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------
  task automatic stop_on_failure();
    $display("tests failed");
    $fatal(1, "stopped at the first failing check");
  endtask

  task automatic compare_data(input string name, input flen_t actual, input flen_t expected);
    if (actual !== expected) begin
      $display("Error at %0t: %s is %h, expected %h", $time, name, actual, expected);
      stop_on_failure();
    end
  endtask

  task automatic compare_tag(input string name, input tag_t actual, input tag_t expected);
    if (actual !== expected) begin
      $display("Error at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
      stop_on_failure();
    end
  endtask

  task automatic compare_fflags(input string name, input fflags_t actual,
                                input fflags_t expected);
    if (actual !== expected) begin
      $display("Error at %0t: %s is %b, expected %b", $time, name, actual, expected);
      stop_on_failure();
    end
  endtask

  task automatic compare_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("Error at %0t: %s is %b, expected %b", $time, name, actual, expected);
      stop_on_failure();
    end
  endtask

  // Output side is sampled mid-cycle ahead of the handshake edge
  always @(negedge i_clk) begin
    expect_t item;
    if (i_reset_n && o_valid && i_ready) begin
      if (expect_q.size() == 0) begin
        $display("Result with tag %0d left the pipe while nothing was pending", o_tag);
        stop_on_failure();
      end else begin
        item = expect_q.pop_front();
        compare_tag("o_tag", o_tag, item.tag);
        compare_data("o_data", o_data, item.data);
        compare_fflags("o_fflags", o_fflags, item.fflags);
        if (check_latency && (cycle_no - item.accept_cycle != item.latency)) begin
          $display("Result with tag %0d came %0d cycles after acceptance instead of %0d",
                   o_tag, cycle_no - item.accept_cycle, item.latency);
          stop_on_failure();
        end
      end
    end
  end

  // ------------------------------------------------------------
  // Stimulus helpers
  // ------------------------------------------------------------
  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic flen_t random_wide();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = next_random();
    lo = next_random();
    return {hi, lo};
  endfunction

  // Raw 64-bit values are almost never boxed
  function automatic flen_t random_operand();
    logic [31:0] sel;
    sel = next_random();
    if (sel[1:0] == 2'b00) begin
      return random_wide();
    end
    return boxed(next_random());
  endfunction

  function automatic single_t random_normal();
    logic [31:0] r;
    r = next_random();
    if (r[30:23] == 8'h00 || r[30:23] == 8'hff) begin
      r[30:23] = 8'h7f;
    end
    return r;
  endfunction

  // Presents one operation and waits until the pipe takes it
  task automatic send_op(input fpu_op_t op, input flen_t rs1, input flen_t rs2);
    expect_t item;
    flen_t   data;
    fflags_t flags;
    i_valid = 1'b1;
    i_op    = op;
    i_tag   = next_tag;
    i_rs1   = rs1;
    i_rs2   = rs2;
    @(negedge i_clk);
    while (!o_ready) begin
      @(negedge i_clk);
    end
    model_result(op, rs1, rs2, data, flags);
    item.tag          = next_tag;
    item.data         = data;
    item.fflags       = flags;
    item.accept_cycle = cycle_no + 1;
    item.latency      = is_slow_op(op) ? 3 : 2;
    expect_q.push_back(item);
    next_tag = next_tag + tag_t'(1);
    @(posedge i_clk);
    #(DRIVE_DELAY);
    i_valid = 1'b0;
    if (is_slow_op(op)) begin
      // One bubble behind a slow op
      @(negedge i_clk);
      compare_bit("o_ready", o_ready, 1'b0);
      @(posedge i_clk);
      #(DRIVE_DELAY);
      if (i_ready) begin
        compare_bit("o_ready", o_ready, 1'b1);
      end
    end
  endtask

  task automatic wait_drain();
    while (expect_q.size() != 0) begin
      @(posedge i_clk);
      #(DRIVE_DELAY);
    end
    repeat (3) begin
      @(posedge i_clk);
      #(DRIVE_DELAY);
    end
  endtask

  // ------------------------------------------------------------
  // Tests
  // ------------------------------------------------------------
  task automatic reset_and_single_test();
    flen_t a;
    flen_t b;
    @(negedge i_clk);
    compare_bit("o_valid", o_valid, 1'b0);
    compare_bit("o_ready", o_ready, 1'b1);
    @(posedge i_clk);
    #(DRIVE_DELAY);
    a = random_wide();
    b = random_wide();
    send_op(OP_FSGNJ_D, a, b);
    wait_drain();
  endtask

  task automatic sign_injection_test();
    fpu_op_t     fast_ops[8] = '{OP_FMV_X_W, OP_FMV_W_X, OP_FSGNJ_S, OP_FSGNJN_S,
                                 OP_FSGNJX_S, OP_FSGNJ_D, OP_FSGNJN_D, OP_FSGNJX_D};
    logic [31:0] sel;
    flen_t       a;
    flen_t       b;
    send_op(OP_FMV_X_W, 64'h0000_0000_8000_0001, 64'h0);
    send_op(OP_FMV_W_X, 64'h1234_5678_9abc_def0, 64'h0);
    send_op(OP_FSGNJ_S, 64'h0000_0000_3f80_0000, boxed(32'h8000_0000));
    send_op(OP_FSGNJX_S, boxed(32'hbf80_0000), 64'h0000_0001_c000_0000);
    for (int n = 0; n < 40; n++) begin
      sel = next_random();
      a   = random_operand();
      b   = random_operand();
      send_op(fast_ops[sel[2:0]], a, b);
    end
    wait_drain();
  endtask

  task automatic compare_ops_test();
    fpu_op_t slow_ops[5] = '{OP_FMIN_S, OP_FMAX_S, OP_FEQ_S, OP_FLT_S, OP_FLE_S};
    // +0, -0, qNaN, sNaN, 1.0, -2.0, unboxed 1.0, +inf
    flen_t   vals[8] = '{64'hffff_ffff_0000_0000, 64'hffff_ffff_8000_0000,
                         64'hffff_ffff_7fc0_0000, 64'hffff_ffff_ff80_0001,
                         64'hffff_ffff_3f80_0000, 64'hffff_ffff_c000_0000,
                         64'h0000_0000_3f80_0000, 64'hffff_ffff_7f80_0000};
    flen_t   a;
    flen_t   b;
    for (int i = 0; i < 8; i++) begin
      for (int k = 0; k < 5; k++) begin
        send_op(slow_ops[k], vals[i], vals[(i + 1) % 8]);
        send_op(slow_ops[k], vals[(i + 1) % 8], vals[i]);
      end
    end
    for (int i = 0; i < 5; i++) begin
      a = boxed(random_normal());
      b = (i == 4) ? a : boxed(random_normal());
      for (int k = 0; k < 5; k++) begin
        send_op(slow_ops[k], a, b);
      end
    end
    wait_drain();
  endtask

  task automatic mixed_stream_test();
    logic [31:0] sel;
    flen_t       a;
    flen_t       b;
    for (int n = 0; n < 30; n++) begin
      sel = next_random();
      a   = random_operand();
      b   = random_operand();
      send_op(fpu_op_t'(4'(sel % 13)), a, b);
    end
    wait_drain();
  endtask

  task automatic back_pressure_test();
    flen_t held_data;
    tag_t  held_tag;
    flen_t a;
    flen_t b;
    check_latency = 1'b0;
    i_ready       = 1'b0;
    a = random_wide();
    b = random_wide();
    send_op(OP_FSGNJN_D, a, b);
    send_op(OP_FMV_W_X, b, a);
    send_op(OP_FLE_S, boxed(32'h3f80_0000), boxed(32'h4000_0000));
    @(negedge i_clk);
    held_data = o_data;
    held_tag  = o_tag;
    repeat (6) begin
      compare_bit("o_valid", o_valid, 1'b1);
      compare_data("o_data", o_data, held_data);
      compare_tag("o_tag", o_tag, held_tag);
      compare_bit("o_ready", o_ready, 1'b0);
      @(negedge i_clk);
    end
    @(posedge i_clk);
    #(DRIVE_DELAY);
    i_ready = 1'b1;
    wait_drain();
    check_latency = 1'b1;
  endtask

  task automatic flush_test();
    flen_t a;
    flen_t b;
    a = random_wide();
    b = random_wide();
    send_op(OP_FSGNJ_D, a, b);
    send_op(OP_FMIN_S, boxed(random_normal()), boxed(32'h3f80_0000));
    send_op(OP_FMV_X_W, b, a);
    i_flush = 1'b1;
    @(posedge i_clk);
    #(DRIVE_DELAY);
    i_flush = 1'b0;
    // Whatever was not taken by the flush edge is dropped
    expect_q.delete();
    @(negedge i_clk);
    compare_bit("o_valid", o_valid, 1'b0);
    @(posedge i_clk);
    #(DRIVE_DELAY);
    send_op(OP_FEQ_S, boxed(32'h4000_0000), boxed(32'h4000_0000));
    send_op(OP_FSGNJX_S, a, b);
    send_op(OP_FMAX_S, boxed(32'hc000_0000), boxed(32'h3f80_0000));
    send_op(OP_FMV_W_X, a, b);
    wait_drain();
  endtask

  initial begin
    i_reset_n     = 1'b0;
    i_flush       = 1'b0;
    i_valid       = 1'b0;
    i_op          = OP_FMV_X_W;
    i_tag         = '0;
    i_rs1         = '0;
    i_rs2         = '0;
    i_ready       = 1'b1;
    rng_state     = 32'd33684;
    next_tag      = '0;
    check_latency = 1'b1;
    repeat (RESET_CYCLES) @(posedge i_clk);
    #(DRIVE_DELAY);
    i_reset_n = 1'b1;
    reset_and_single_test();
    sign_injection_test();
    compare_ops_test();
    mixed_stream_test();
    back_pressure_test();
    flush_test();
    $display("all tests passed");
    $finish;
  end

endmodule

/* source/fpu_pipe_top.sv */
`timescale 1ns/100ps

module fpu_pipe_top (
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  logic             i_flush,

  input  logic             i_valid,
  input  fpu_pkg::fpu_op_t i_op,
  input  fpu_pkg::tag_t    i_tag,
  input  fpu_pkg::flen_t   i_rs1,
  input  fpu_pkg::flen_t   i_rs2,
  output logic             o_ready,

  output logic             o_valid,
  input  logic             i_ready,
  output fpu_pkg::tag_t    o_tag,
  output fpu_pkg::flen_t   o_data,
  output fpu_pkg::fflags_t o_fflags
);

  import fpu_pkg::*;

  logic    w_stall;

  logic    w_iss_fast_valid;
  logic    w_iss_slow_valid;
  fpu_op_t w_iss_op;
  tag_t    w_iss_tag;
  flen_t   w_iss_rs1;
  flen_t   w_iss_rs2;

  logic    w_fast_valid;
  tag_t    w_fast_tag;
  flen_t   w_fast_data;

  logic    w_slow_valid;
  tag_t    w_slow_tag;
  flen_t   w_slow_data;
  fflags_t w_slow_fflags;

  fpu_issue_stage u_issue (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_flush      (i_flush),
    .i_stall      (w_stall),
    .i_valid      (i_valid),
    .i_op         (i_op),
    .i_tag        (i_tag),
    .i_rs1        (i_rs1),
    .i_rs2        (i_rs2),
    .o_ready      (o_ready),
    .o_fast_valid (w_iss_fast_valid),
    .o_slow_valid (w_iss_slow_valid),
    .o_op         (w_iss_op),
    .o_tag        (w_iss_tag),
    .o_rs1        (w_iss_rs1),
    .o_rs2        (w_iss_rs2)
  );

  fpu_sign_move_unit u_sign_move (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_flush   (i_flush),
    .i_stall   (w_stall),
    .i_valid   (w_iss_fast_valid),
    .i_op      (w_iss_op),
    .i_tag     (w_iss_tag),
    .i_rs1     (w_iss_rs1),
    .i_rs2     (w_iss_rs2),
    .o_valid   (w_fast_valid),
    .o_tag     (w_fast_tag),
    .o_data    (w_fast_data)
  );

  fpu_compare_unit u_compare (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_flush   (i_flush),
    .i_stall   (w_stall),
    .i_valid   (w_iss_slow_valid),
    .i_op      (w_iss_op),
    .i_tag     (w_iss_tag),
    .i_rs1     (w_iss_rs1),
    .i_rs2     (w_iss_rs2),
    .o_valid   (w_slow_valid),
    .o_tag     (w_slow_tag),
    .o_data    (w_slow_data),
    .o_fflags  (w_slow_fflags)
  );

  fpu_result_merge u_merge (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_flush       (i_flush),
    .i_ready       (i_ready),
    .i_fast_valid  (w_fast_valid),
    .i_fast_tag    (w_fast_tag),
    .i_fast_data   (w_fast_data),
    .i_slow_valid  (w_slow_valid),
    .i_slow_tag    (w_slow_tag),
    .i_slow_data   (w_slow_data),
    .i_slow_fflags (w_slow_fflags),
    .o_valid       (o_valid),
    .o_tag         (o_tag),
    .o_data        (o_data),
    .o_fflags      (o_fflags),
    .o_stall       (w_stall)
  );

endmodule

/* source/fpu_result_merge.sv */
`timescale 1ns/100ps

module fpu_result_merge (
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  logic             i_flush,
  input  logic             i_ready,

  input  logic             i_fast_valid,
  input  fpu_pkg::tag_t    i_fast_tag,
  input  fpu_pkg::flen_t   i_fast_data,

  input  logic             i_slow_valid,
  input  fpu_pkg::tag_t    i_slow_tag,
  input  fpu_pkg::flen_t   i_slow_data,
  input  fpu_pkg::fflags_t i_slow_fflags,

  output logic             o_valid,
  output fpu_pkg::tag_t    o_tag,
  output fpu_pkg::flen_t   o_data,
  output fpu_pkg::fflags_t o_fflags,
  output logic             o_stall
);

  import fpu_pkg::*;

  // Result held but not taken freezes the whole pipe
  assign o_stall = o_valid & ~i_ready;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_valid <= 1'b0;
    end else if (i_flush) begin
      o_valid <= 1'b0;
    end else if (!o_stall) begin
      o_valid <= i_fast_valid | i_slow_valid;
    end
  end

  // At most one unit is valid in a given cycle
  always_ff @(posedge i_clk) begin
    if (!o_stall) begin
      if (i_slow_valid) begin
        o_tag    <= i_slow_tag;
        o_data   <= i_slow_data;
        o_fflags <= i_slow_fflags;
      end else begin
        o_tag    <= i_fast_tag;
        o_data   <= i_fast_data;
        o_fflags <= fflags_t'(0);
      end
    end
  end

endmodule

/* source/fpu_compare_unit.sv */
`timescale 1ns/100ps

module fpu_compare_unit (
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  logic             i_flush,
  input  logic             i_stall,

  input  logic             i_valid,
  input  fpu_pkg::fpu_op_t i_op,
  input  fpu_pkg::tag_t    i_tag,
  input  fpu_pkg::flen_t   i_rs1,
  input  fpu_pkg::flen_t   i_rs2,

  output logic             o_valid,
  output fpu_pkg::tag_t    o_tag,
  output fpu_pkg::flen_t   o_data,
  output fpu_pkg::fflags_t o_fflags
);

  import fpu_pkg::*;

  single_t w_a;
  single_t w_b;
  logic    w_a_nan;
  logic    w_b_nan;

  logic    r_s1_valid;
  fpu_op_t r_s1_op;
  tag_t    r_s1_tag;
  single_t r_s1_a;
  single_t r_s1_b;
  logic    r_s1_a_qnan, r_s1_a_snan;
  logic    r_s1_b_qnan, r_s1_b_snan;
  logic    r_s1_both_zero;
  logic    r_s1_mag_lt, r_s1_mag_eq;
  logic    r_s1_sign_a, r_s1_sign_b;

  logic    w_a_is_nan, w_b_is_nan;
  logic    w_any_nan, w_any_snan;
  logic    w_lt_total, w_lt, w_eq;
  flen_t   w_result;
  fflags_t w_fflags;

  // ------------------------------------------------------------
  // Stage one: unbox, classify, compare magnitudes
  // ------------------------------------------------------------
  assign w_a     = unbox_s(i_rs1);
  assign w_b     = unbox_s(i_rs2);
  assign w_a_nan = (&w_a[30:23]) & (|w_a[22:0]);
  assign w_b_nan = (&w_b[30:23]) & (|w_b[22:0]);

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_s1_valid <= 1'b0;
    end else if (i_flush) begin
      r_s1_valid <= 1'b0;
    end else if (!i_stall) begin
      r_s1_valid <= i_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_stall) begin
      r_s1_op        <= i_op;
      r_s1_tag       <= i_tag;
      r_s1_a         <= w_a;
      r_s1_b         <= w_b;
      r_s1_a_qnan    <= w_a_nan & w_a[22];
      r_s1_a_snan    <= w_a_nan & ~w_a[22];
      r_s1_b_qnan    <= w_b_nan & w_b[22];
      r_s1_b_snan    <= w_b_nan & ~w_b[22];
      r_s1_both_zero <= ~(|w_a[30:0]) & ~(|w_b[30:0]);
      r_s1_mag_lt    <= w_a[30:0] < w_b[30:0];
      r_s1_mag_eq    <= w_a[30:0] == w_b[30:0];
      r_s1_sign_a    <= w_a[31];
      r_s1_sign_b    <= w_b[31];
    end
  end

  // ------------------------------------------------------------
  // Stage two: pick the result and flags
  // ------------------------------------------------------------
  assign w_a_is_nan = r_s1_a_qnan | r_s1_a_snan;
  assign w_b_is_nan = r_s1_b_qnan | r_s1_b_snan;
  assign w_any_nan  = w_a_is_nan | w_b_is_nan;
  assign w_any_snan = r_s1_a_snan | r_s1_b_snan;

  // Ordering where -0 sorts below +0
  assign w_lt_total = (r_s1_sign_a != r_s1_sign_b) ? r_s1_sign_a :
                      r_s1_sign_a ? ~r_s1_mag_lt & ~r_s1_mag_eq : r_s1_mag_lt;
  assign w_lt = w_lt_total & ~r_s1_both_zero;
  assign w_eq = (r_s1_mag_eq & (r_s1_sign_a == r_s1_sign_b)) | r_s1_both_zero;

  always_comb begin
    w_result = '0;
    w_fflags = '0;
    case (r_s1_op)
      OP_FMIN_S, OP_FMAX_S: begin
        if (w_a_is_nan & w_b_is_nan) begin
          w_result = {{(FLEN_W-SINGLE_W){1'b1}}, CANON_NAN_S};
        end else if (w_a_is_nan) begin
          w_result = {{(FLEN_W-SINGLE_W){1'b1}}, r_s1_b};
        end else if (w_b_is_nan) begin
          w_result = {{(FLEN_W-SINGLE_W){1'b1}}, r_s1_a};
        end else if (w_lt_total ^ (r_s1_op == OP_FMAX_S)) begin
          w_result = {{(FLEN_W-SINGLE_W){1'b1}}, r_s1_a};
        end else begin
          w_result = {{(FLEN_W-SINGLE_W){1'b1}}, r_s1_b};
        end
        w_fflags[NV_BIT] = w_any_snan;
      end
      OP_FEQ_S: begin
        w_result[0]      = ~w_any_nan & w_eq;
        w_fflags[NV_BIT] = w_any_snan;
      end
      OP_FLT_S: begin
        w_result[0]      = ~w_any_nan & w_lt;
        w_fflags[NV_BIT] = w_any_nan;
      end
      OP_FLE_S: begin
        w_result[0]      = ~w_any_nan & (w_lt | w_eq);
        w_fflags[NV_BIT] = w_any_nan;
      end
      default: begin
        w_result = '0;
      end
    endcase
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_valid <= 1'b0;
    end else if (i_flush) begin
      o_valid <= 1'b0;
    end else if (!i_stall) begin
      o_valid <= r_s1_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_stall) begin
      o_tag    <= r_s1_tag;
      o_data   <= w_result;
      o_fflags <= w_fflags;
    end
  end

endmodule

/* source/fpu_sign_move_unit.sv */
`timescale 1ns/100ps

module fpu_sign_move_unit (
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  logic             i_flush,
  input  logic             i_stall,

  input  logic             i_valid,
  input  fpu_pkg::fpu_op_t i_op,
  input  fpu_pkg::tag_t    i_tag,
  input  fpu_pkg::flen_t   i_rs1,
  input  fpu_pkg::flen_t   i_rs2,

  output logic             o_valid,
  output fpu_pkg::tag_t    o_tag,
  output fpu_pkg::flen_t   o_data
);

  import fpu_pkg::*;

  single_t w_rs1_s;
  single_t w_rs2_s;
  flen_t   w_result;

  assign w_rs1_s = unbox_s(i_rs1);
  assign w_rs2_s = unbox_s(i_rs2);

  // ------------------------------------------------------------
  // Moves and sign injection
  // ------------------------------------------------------------
  always_comb begin
    case (i_op)
      OP_FMV_X_W: begin
        w_result = {{(FLEN_W-SINGLE_W){i_rs1[SINGLE_W-1]}}, i_rs1[SINGLE_W-1:0]};
      end
      OP_FMV_W_X: begin
        w_result = {{(FLEN_W-SINGLE_W){1'b1}}, i_rs1[SINGLE_W-1:0]};
      end
      OP_FSGNJ_S: begin
        w_result = {{(FLEN_W-SINGLE_W){1'b1}}, w_rs2_s[SINGLE_W-1], w_rs1_s[SINGLE_W-2:0]};
      end
      OP_FSGNJN_S: begin
        w_result = {{(FLEN_W-SINGLE_W){1'b1}}, ~w_rs2_s[SINGLE_W-1], w_rs1_s[SINGLE_W-2:0]};
      end
      OP_FSGNJX_S: begin
        w_result = {{(FLEN_W-SINGLE_W){1'b1}},
                    w_rs1_s[SINGLE_W-1] ^ w_rs2_s[SINGLE_W-1],
                    w_rs1_s[SINGLE_W-2:0]};
      end
      OP_FSGNJ_D: begin
        w_result = {i_rs2[FLEN_W-1], i_rs1[FLEN_W-2:0]};
      end
      OP_FSGNJN_D: begin
        w_result = {~i_rs2[FLEN_W-1], i_rs1[FLEN_W-2:0]};
      end
      OP_FSGNJX_D: begin
        w_result = {i_rs1[FLEN_W-1] ^ i_rs2[FLEN_W-1], i_rs1[FLEN_W-2:0]};
      end
      default: begin
        w_result = '0;
      end
    endcase
  end

  // ------------------------------------------------------------
  // Result register
  // ------------------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_valid <= 1'b0;
    end else if (i_flush) begin
      o_valid <= 1'b0;
    end else if (!i_stall) begin
      o_valid <= i_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_stall) begin
      o_tag  <= i_tag;
      o_data <= w_result;
    end
  end

endmodule

/* source/fpu_issue_stage.sv */
`timescale 1ns/100ps

module fpu_issue_stage (
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  logic             i_flush,
  input  logic             i_stall,

  input  logic             i_valid,
  input  fpu_pkg::fpu_op_t i_op,
  input  fpu_pkg::tag_t    i_tag,
  input  fpu_pkg::flen_t   i_rs1,
  input  fpu_pkg::flen_t   i_rs2,
  output logic             o_ready,

  output logic             o_fast_valid,
  output logic             o_slow_valid,
  output fpu_pkg::fpu_op_t o_op,
  output fpu_pkg::tag_t    o_tag,
  output fpu_pkg::flen_t   o_rs1,
  output fpu_pkg::flen_t   o_rs2
);

  import fpu_pkg::*;

  logic w_slow_op;
  logic w_accept;

  // Min/max and compares go down the two-stage path
  always_comb begin
    w_slow_op = i_op inside {OP_FMIN_S, OP_FMAX_S, OP_FEQ_S, OP_FLT_S, OP_FLE_S};
  end

  // One bubble behind every slow op keeps the two units from
  // finishing in the same cycle
  assign o_ready  = ~o_slow_valid & ~i_stall;
  assign w_accept = i_valid & o_ready;

  // ------------------------------------------------------------
  // Slot valid bits
  // ------------------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_fast_valid <= 1'b0;
      o_slow_valid <= 1'b0;
    end else if (i_flush) begin
      o_fast_valid <= 1'b0;
      o_slow_valid <= 1'b0;
    end else if (!i_stall) begin
      o_fast_valid <= w_accept & ~w_slow_op;
      o_slow_valid <= w_accept & w_slow_op;
    end
  end

  // Payload shared by both slots
  always_ff @(posedge i_clk) begin
    if (w_accept) begin
      o_op  <= i_op;
      o_tag <= i_tag;
      o_rs1 <= i_rs1;
      o_rs2 <= i_rs2;
    end
  end

endmodule

/* source/fpu_pkg.sv */
package fpu_pkg;

  // ------------------------------------------------------------
  // Widths
  // ------------------------------------------------------------
  localparam int FLEN_W   = 64;
  localparam int SINGLE_W = 32;
  localparam int TAG_W    = 6;
  localparam int FFLAGS_W = 5;

  typedef logic [FLEN_W-1:0]   flen_t;
  typedef logic [SINGLE_W-1:0] single_t;
  typedef logic [TAG_W-1:0]    tag_t;
  typedef logic [FFLAGS_W-1:0] fflags_t;

  // Flag order is NV DZ OF UF NX, MSB first
  localparam int NV_BIT = 4;

  // ------------------------------------------------------------
  // Operations
  // ------------------------------------------------------------
  typedef enum logic [3:0] {
    OP_FMV_X_W  = 4'h0,
    OP_FMV_W_X  = 4'h1,
    OP_FSGNJ_S  = 4'h2,
    OP_FSGNJN_S = 4'h3,
    OP_FSGNJX_S = 4'h4,
    OP_FSGNJ_D  = 4'h5,
    OP_FSGNJN_D = 4'h6,
    OP_FSGNJX_D = 4'h7,
    OP_FMIN_S   = 4'h8,
    OP_FMAX_S   = 4'h9,
    OP_FEQ_S    = 4'ha,
    OP_FLT_S    = 4'hb,
    OP_FLE_S    = 4'hc
  } fpu_op_t;

  // ------------------------------------------------------------
  // NaN boxing
  // ------------------------------------------------------------
  localparam single_t CANON_NAN_S = 32'h7fc0_0000;

  // Single value only counts when the upper word is all ones
  function automatic single_t unbox_s(input flen_t value);
    if (&value[FLEN_W-1:SINGLE_W]) begin
      return value[SINGLE_W-1:0];
    end else begin
      return CANON_NAN_S;
    end
  endfunction

endpackage
